// ==== design/usb_aon_pkg.sv ====
//////////////////////////////////////////////////
// Shared constants and types for the always-on
// USB wake detector. Imported by the modules that
// need them, or referenced by scoped name in
// module headers.
//////////////////////////////////////////////////

package usb_aon_pkg;

  // Synchronizer flops in front of every filter and on the pull-up enables
  localparam int unsigned sync_stages_lp = 2;

  // Stable-sample counts for the event filters
  // AON clock is about 200 kHz, so 4 samples is roughly 20 us
  localparam int unsigned not_idle_cycles_lp   = 4;
  localparam int unsigned bus_reset_cycles_lp  = 3;
  localparam int unsigned sense_lost_cycles_lp = 3;

  // Detector state
  // Idle means the USB IP owns the pull-ups
  // Active means the detector holds them and watches the bus
  typedef enum logic {
    AWK_IDLE   = 1'b0,
    AWK_ACTIVE = 1'b1
  } awk_state_e;

endpackage

// ==== design/usb_sync_filter.sv ====
//////////////////////////////////////////////////
// Synchronizer plus stable-count debounce filter.
// The output follows the input only after the
// synchronized value has held for Cycles samples.
// Pulses shorter than that never reach the output.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module usb_sync_filter #(
  parameter int unsigned Cycles = 4
) (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,
  input  logic filter_i,
  output logic filter_o
);

  import usb_aon_pkg::*;

  // Synchronizer chain, oldest sample at the top
  logic [sync_stages_lp-1:0] sync_q;
  logic                      synced;

  // Previous synchronized sample and run length counter
  logic                       sample_q;
  logic [$clog2(Cycles+1)-1:0] cnt_d, cnt_q;
  logic                       filter_q;

  assign synced = sync_q[sync_stages_lp-1];

  // Restart the count on any change, saturate once the run is long enough
  always_comb begin : proc_cnt
    if (synced != sample_q) begin
      cnt_d = '0;
    end else if (cnt_q >= Cycles - 1) begin
      cnt_d = cnt_q;
    end else begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin : proc_filter
    if (!rst_aon_ni) begin
      sync_q   <= '0;
      sample_q <= 1'b0;
      cnt_q    <= '0;
      filter_q <= 1'b0;
    end else begin
      sync_q   <= {sync_q[sync_stages_lp-2:0], filter_i};
      sample_q <= synced;
      cnt_q    <= cnt_d;
      // Take the new level once the run reaches the required length
      if (cnt_d == Cycles - 1) begin
        filter_q <= sample_q;
      end
    end
  end

  assign filter_o = filter_q;

endmodule

// ==== design/usb_line_monitor.sv ====
//////////////////////////////////////////////////
// Bus line monitor for the wake detector.
// Builds the raw not-idle, SE0 and sense-lost
// conditions from the pins and debounces each one
// through its own sync filter.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module usb_line_monitor #(
  parameter int unsigned not_idle_cycles_p   = usb_aon_pkg::not_idle_cycles_lp,
  parameter int unsigned bus_reset_cycles_p  = usb_aon_pkg::bus_reset_cycles_lp,
  parameter int unsigned sense_lost_cycles_p = usb_aon_pkg::sense_lost_cycles_lp
) (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,
  input  logic usb_dp_i,
  input  logic usb_dn_i,
  input  logic usb_sense_i,
  input  logic dppullup_en_i,
  input  logic dnpullup_en_i,
  output logic event_not_idle_o,
  output logic event_bus_reset_o,
  output logic event_sense_lost_o
);

  logic not_idle_raw;
  logic se0_raw;
  logic sense_lost_raw;

  // In suspend the pull-ups set the line state
  // Any difference means the host is driving the bus
  // Covers J to K resume and J to SE0 reset, and is immune to pin flipping
  assign not_idle_raw = (usb_dp_i != dppullup_en_i) | (usb_dn_i != dnpullup_en_i);

  // SE0 is both lines low
  assign se0_raw = ~usb_dp_i & ~usb_dn_i;

  // VBUS sense dropped
  assign sense_lost_raw = ~usb_sense_i;

  usb_sync_filter #(
    .Cycles (not_idle_cycles_p)
  ) u_filter_not_idle (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .filter_i   (not_idle_raw),
    .filter_o   (event_not_idle_o)
  );

  usb_sync_filter #(
    .Cycles (bus_reset_cycles_p)
  ) u_filter_bus_reset (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .filter_i   (se0_raw),
    .filter_o   (event_bus_reset_o)
  );

  usb_sync_filter #(
    .Cycles (sense_lost_cycles_p)
  ) u_filter_sense_lost (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .filter_i   (sense_lost_raw),
    .filter_o   (event_sense_lost_o)
  );

endmodule

// ==== design/usb_pullup_hold.sv ====
//////////////////////////////////////////////////
// Pull-up enable hold for the wake detector.
// While idle the IP drives the pull-ups directly.
// While active a frozen copy of the synchronized
// IP enables keeps the line in its idle state.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module usb_pullup_hold (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,
  input  logic usbdev_dppullup_en_i,
  input  logic usbdev_dnpullup_en_i,
  input  logic wake_detect_active_i,
  output logic usb_dppullup_en_o,
  output logic usb_dnpullup_en_o
);

  import usb_aon_pkg::*;

  // Bit 1 is D+, bit 0 is D-
  logic [sync_stages_lp-1:0][1:0] en_sync_q;
  logic [1:0]                     en_synced;
  logic [1:0]                     en_hold_q;

  assign en_synced = en_sync_q[sync_stages_lp-1];

  // IP enables cross from the IP clock domain
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin : proc_en_sync
    if (!rst_aon_ni) begin
      en_sync_q <= '0;
    end else begin
      en_sync_q <= {en_sync_q[sync_stages_lp-2:0], {usbdev_dppullup_en_i, usbdev_dnpullup_en_i}};
    end
  end

  // Copy reloads only while idle
  // Frozen for the whole active period
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin : proc_en_hold
    if (!rst_aon_ni) begin
      en_hold_q <= 2'b00;
    end else if (!wake_detect_active_i) begin
      en_hold_q <= en_synced;
    end
  end

  // Live IP enables when idle, held copy when active
  assign usb_dppullup_en_o = wake_detect_active_i ? en_hold_q[1] : usbdev_dppullup_en_i;
  assign usb_dnpullup_en_o = wake_detect_active_i ? en_hold_q[0] : usbdev_dnpullup_en_i;

endmodule

// ==== design/usb_aon_wake_ctrl.sv ====
//////////////////////////////////////////////////
// Wake detector control.
// Two-state machine entered by a suspend request
// and left by a wake acknowledge. While active the
// debounced events set sticky flags and a wake
// request, all cleared once the state is idle.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module usb_aon_wake_ctrl (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,
  input  logic suspend_req_aon_i,
  input  logic wake_ack_aon_i,
  input  logic event_not_idle_i,
  input  logic event_bus_reset_i,
  input  logic event_sense_lost_i,
  output logic wake_detect_active_o,
  output logic wake_req_aon_o,
  output logic bus_not_idle_aon_o,
  output logic bus_reset_aon_o,
  output logic sense_lost_aon_o
);

  import usb_aon_pkg::*;

  awk_state_e state_d, state_q;
  logic       active;

  logic bus_not_idle_d, bus_not_idle_q;
  logic bus_reset_d, bus_reset_q;
  logic sense_lost_d, sense_lost_q;
  logic wake_req_d, wake_req_q;

  assign active = (state_q == AWK_ACTIVE);

  always_comb begin : proc_fsm
    state_d = state_q;
    unique case (state_q)
      // IP owns the bus, only a suspend request moves us on
      AWK_IDLE: begin
        if (suspend_req_aon_i) begin
          state_d = AWK_ACTIVE;
        end
      end
      // Monitoring, hand control back once the IP acknowledges the wake
      AWK_ACTIVE: begin
        if (wake_ack_aon_i) begin
          state_d = AWK_IDLE;
        end
      end
      default: state_d = AWK_IDLE;
    endcase
  end

  // Sticky flags, gated by the registered state so they drop one edge after idle
  assign bus_not_idle_d = (event_not_idle_i | bus_not_idle_q) & active;
  assign bus_reset_d    = (event_bus_reset_i | bus_reset_q) & active;
  assign sense_lost_d   = (event_sense_lost_i | sense_lost_q) & active;

  // Any event while active asks for power up
  assign wake_req_d = active &
                      (event_not_idle_i | event_bus_reset_i | event_sense_lost_i | wake_req_q);

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin : proc_regs
    if (!rst_aon_ni) begin
      state_q        <= AWK_IDLE;
      bus_not_idle_q <= 1'b0;
      bus_reset_q    <= 1'b0;
      sense_lost_q   <= 1'b0;
      wake_req_q     <= 1'b0;
    end else begin
      state_q        <= state_d;
      bus_not_idle_q <= bus_not_idle_d;
      bus_reset_q    <= bus_reset_d;
      sense_lost_q   <= sense_lost_d;
      wake_req_q     <= wake_req_d;
    end
  end

  assign wake_detect_active_o = active;
  assign wake_req_aon_o       = wake_req_q;
  assign bus_not_idle_aon_o   = bus_not_idle_q;
  assign bus_reset_aon_o      = bus_reset_q;
  assign sense_lost_aon_o     = sense_lost_q;

endmodule

// ==== design/usb_aon_wake.sv ====
//////////////////////////////////////////////////
// Always-on USB wake detector, RTL top level.
// Runs on the AON clock while the USB IP is off.
// Suspend and acknowledge arrive already in the
// AON domain. Outputs are the held pull-ups, the
// sticky event flags and the wake request.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module usb_aon_wake (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,

  // Chip pins
  input  logic usb_dp_i,
  input  logic usb_dn_i,
  input  logic usb_sense_i,

  // Pull-up enables from the IP
  input  logic usbdev_dppullup_en_i,
  input  logic usbdev_dnpullup_en_i,

  // Requests already synchronized to AON
  input  logic suspend_req_aon_i,
  input  logic wake_ack_aon_i,

  // Pull-ups kept alive in low power
  output logic usb_dppullup_en_o,
  output logic usb_dnpullup_en_o,

  // Power up request and what caused it
  output logic wake_req_aon_o,
  output logic bus_not_idle_aon_o,
  output logic bus_reset_aon_o,
  output logic sense_lost_aon_o,

  // Detector state for debug
  output logic wake_detect_active_aon_o
);

  logic wake_detect_active;
  logic event_not_idle;
  logic event_bus_reset;
  logic event_sense_lost;

  // Line is compared against the pull-ups actually driven
  usb_line_monitor u_line_monitor (
    .clk_aon_i          (clk_aon_i),
    .rst_aon_ni         (rst_aon_ni),
    .usb_dp_i           (usb_dp_i),
    .usb_dn_i           (usb_dn_i),
    .usb_sense_i        (usb_sense_i),
    .dppullup_en_i      (usb_dppullup_en_o),
    .dnpullup_en_i      (usb_dnpullup_en_o),
    .event_not_idle_o   (event_not_idle),
    .event_bus_reset_o  (event_bus_reset),
    .event_sense_lost_o (event_sense_lost)
  );

  usb_pullup_hold u_pullup_hold (
    .clk_aon_i            (clk_aon_i),
    .rst_aon_ni           (rst_aon_ni),
    .usbdev_dppullup_en_i (usbdev_dppullup_en_i),
    .usbdev_dnpullup_en_i (usbdev_dnpullup_en_i),
    .wake_detect_active_i (wake_detect_active),
    .usb_dppullup_en_o    (usb_dppullup_en_o),
    .usb_dnpullup_en_o    (usb_dnpullup_en_o)
  );

  usb_aon_wake_ctrl u_wake_ctrl (
    .clk_aon_i            (clk_aon_i),
    .rst_aon_ni           (rst_aon_ni),
    .suspend_req_aon_i    (suspend_req_aon_i),
    .wake_ack_aon_i       (wake_ack_aon_i),
    .event_not_idle_i     (event_not_idle),
    .event_bus_reset_i    (event_bus_reset),
    .event_sense_lost_i   (event_sense_lost),
    .wake_detect_active_o (wake_detect_active),
    .wake_req_aon_o       (wake_req_aon_o),
    .bus_not_idle_aon_o   (bus_not_idle_aon_o),
    .bus_reset_aon_o      (bus_reset_aon_o),
    .sense_lost_aon_o     (sense_lost_aon_o)
  );

  assign wake_detect_active_aon_o = wake_detect_active;

endmodule

// ==== tb/usb_aon_wake_checker.sv ====
//////////////////////////////////////////////////
// Concurrent assertions for the wake detector.
// Bound to every usb_aon_wake instance and only
// observes the top level ports.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module usb_aon_wake_checker (
  input logic clk_aon_i,
  input logic rst_aon_ni,
  input logic active_i,
  input logic wake_req_i,
  input logic bus_not_idle_i,
  input logic bus_reset_i,
  input logic sense_lost_i,
  input logic dppullup_en_i,
  input logic dnpullup_en_i
);

  import usb_aon_pkg::*;

  awk_state_e  state_view;
  // Number of failed assertions over the run
  int unsigned fail_cnt = 0;

  // Active output mirrors the registered state
  assign state_view = awk_state_e'(active_i);

  // Wake request only ever follows an active cycle
  wake_req_after_active_a: assert property (
    @(posedge clk_aon_i) disable iff (!rst_aon_ni)
    wake_req_i |-> $past(state_view == AWK_ACTIVE)
  ) else begin
    $error("wake request without a preceding active cycle");
    fail_cnt++;
  end

  // Held pull-ups frozen for the whole active period
  pullup_hold_stable_a: assert property (
    @(posedge clk_aon_i) disable iff (!rst_aon_ni)
    ((state_view == AWK_ACTIVE) && $past(state_view == AWK_ACTIVE))
      |-> $stable({dppullup_en_i, dnpullup_en_i})
  ) else begin
    $error("pull-up outputs moved while the detector was active");
    fail_cnt++;
  end

  // Flags set only by events seen while active
  no_flag_rise_idle_a: assert property (
    @(posedge clk_aon_i) disable iff (!rst_aon_ni)
    ($rose(bus_not_idle_i) || $rose(bus_reset_i) || $rose(sense_lost_i))
      |-> $past(state_view == AWK_ACTIVE)
  ) else begin
    $error("event flag rose while the detector was idle");
    fail_cnt++;
  end

  active_known_a: assert property (
    @(posedge clk_aon_i) disable iff (!rst_aon_ni)
    !$isunknown(active_i)
  ) else begin
    $error("active output unknown after reset");
    fail_cnt++;
  end

endmodule

bind usb_aon_wake usb_aon_wake_checker u_checker (
  .clk_aon_i      (clk_aon_i),
  .rst_aon_ni     (rst_aon_ni),
  .active_i       (wake_detect_active_aon_o),
  .wake_req_i     (wake_req_aon_o),
  .bus_not_idle_i (bus_not_idle_aon_o),
  .bus_reset_i    (bus_reset_aon_o),
  .sense_lost_i   (sense_lost_aon_o),
  .dppullup_en_i  (usb_dppullup_en_o),
  .dnpullup_en_i  (usb_dnpullup_en_o)
);

// ==== tb/tb_usb_aon_wake.sv ====
//////////////////////////////////////////////////
// Directed testbench for the always-on USB wake
// detector. Walks through idle follow, suspend
// entry, resume, bus reset, sense loss and glitch
// rejection, one task per behavior.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_usb_aon_wake;

  logic       clk_aon = 1'b0;
  logic       rst_aon_n;
  logic       usb_dp;
  logic       usb_dn;
  logic       usb_sense;
  logic       ip_dp_en;
  logic       ip_dn_en;
  logic       suspend_req;
  logic       wake_ack;
  logic       dppullup_en;
  logic       dnpullup_en;
  logic       wake_req;
  logic       bus_not_idle;
  logic       bus_reset;
  logic       sense_lost;
  logic       active;
  // Active, wake, not-idle, reset, sense from MSB down
  logic [4:0] status;
  logic [1:0] pullups;
  logic [7:0] lfsr_q;
  int         err_cnt;
  int         check_cnt;

  assign status  = {active, wake_req, bus_not_idle, bus_reset, sense_lost};
  assign pullups = {dppullup_en, dnpullup_en};

  // Free running AON clock with an 8 ns period
  always #4 clk_aon = ~clk_aon;

  usb_aon_wake usb_aon_wake_i (
    .clk_aon_i                (clk_aon),
    .rst_aon_ni               (rst_aon_n),
    .usb_dp_i                 (usb_dp),
    .usb_dn_i                 (usb_dn),
    .usb_sense_i              (usb_sense),
    .usbdev_dppullup_en_i     (ip_dp_en),
    .usbdev_dnpullup_en_i     (ip_dn_en),
    .suspend_req_aon_i        (suspend_req),
    .wake_ack_aon_i           (wake_ack),
    .usb_dppullup_en_o        (dppullup_en),
    .usb_dnpullup_en_o        (dnpullup_en),
    .wake_req_aon_o           (wake_req),
    .bus_not_idle_aon_o       (bus_not_idle),
    .bus_reset_aon_o          (bus_reset),
    .sense_lost_aon_o         (sense_lost),
    .wake_detect_active_aon_o (active)
  );

  // Galois LFSR with taps x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {1'b0, s[7:1]} ^ (s[0] ? 8'hB8 : 8'h00);
  endfunction

  task automatic check_eq(input string what, input logic [4:0] got, input logic [4:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // Poll on falling edges until the masked status matches
  task automatic wait_status(input string what, input logic [4:0] mask,
                             input logic [4:0] value, input int limit);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done && (n < limit)) begin
      @(negedge clk_aon);
      n++;
      done = ((status & mask) === value);
    end
    if (!done) begin
      $display("Timeout: %s not seen within %0d clocks", what, limit);
      err_cnt++;
    end
  endtask

  // One LFSR bit per test picks the bus speed
  task automatic pick_speed(output logic [1:0] pat);
    logic fs;
    fs     = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    // Full speed idles with D+ pulled up, low speed with D-
    pat = fs ? 2'b10 : 2'b01;
  endtask

  // IP enables and the line move together so the monitor never sees a mismatch
  task automatic set_idle(input logic [1:0] pat);
    {ip_dp_en, ip_dn_en} = pat;
    {usb_dp, usb_dn}     = pat;
    usb_sense            = 1'b1;
    // Long enough for any earlier event to drain out of the filters
    repeat (10) @(negedge clk_aon);
  endtask

  task automatic enter_suspend();
    // Let the synchronized copy settle before the hold freezes it
    repeat (4) @(negedge clk_aon);
    suspend_req = 1'b1;
    @(negedge clk_aon);
    suspend_req = 1'b0;
    wait_status("detector active", 5'b10000, 5'b10000, 20);
    check_eq("status on entry", status, 5'b10000);
  endtask

  task automatic leave_suspend();
    wake_ack = 1'b1;
    @(negedge clk_aon);
    wake_ack = 1'b0;
    // Flags trail the state by one edge
    wait_status("return to idle", 5'b11111, 5'b00000, 3);
  endtask

  task automatic idle_follow();
    logic [1:0] pat;
    pick_speed(pat);
    check_eq("status after reset", status, 5'b00000);
    set_idle(pat);
    check_eq("idle pull-ups", {3'b000, pullups}, {3'b000, pat});
    // Idle pull-ups track the IP directly, well before the synchronizer catches up
    {ip_dp_en, ip_dn_en} = ~pat;
    {usb_dp, usb_dn}     = ~pat;
    @(negedge clk_aon);
    check_eq("idle pull-ups inverted", {3'b000, pullups}, {3'b000, ~pat});
    set_idle(~pat);
    check_eq("status while idle", status, 5'b00000);
  endtask

  task automatic suspend_entry();
    logic [1:0] pat;
    pick_speed(pat);
    set_idle(pat);
    enter_suspend();
    // IP enables move while the line stays at J and the held pull-ups must not follow
    {ip_dp_en, ip_dn_en} = ~pat;
    repeat (3) begin
      @(negedge clk_aon);
      check_eq("held pull-ups", {3'b000, pullups}, {3'b000, pat});
    end
    check_eq("status while held", status, 5'b10000);
    {ip_dp_en, ip_dn_en} = pat;
    leave_suspend();
  endtask

  task automatic resume_wake();
    logic [1:0] pat;
    pick_speed(pat);
    set_idle(pat);
    enter_suspend();
    // K is the inverse of the J idle state
    {usb_dp, usb_dn} = ~pat;
    repeat (10) @(negedge clk_aon);
    {usb_dp, usb_dn} = pat;
    wait_status("resume flags", 5'b11100, 5'b11100, 20);
    check_eq("status after resume", status, 5'b11100);
    leave_suspend();
    check_eq("status after ack", status, 5'b00000);
    set_idle(~pat);
    check_eq("pull-ups follow IP", {3'b000, pullups}, {3'b000, ~pat});
  endtask

  task automatic bus_reset_wake();
    logic [1:0] pat;
    pick_speed(pat);
    set_idle(pat);
    enter_suspend();
    // SE0 also differs from the held J, so not-idle rises too
    {usb_dp, usb_dn} = 2'b00;
    repeat (10) @(negedge clk_aon);
    {usb_dp, usb_dn} = pat;
    wait_status("bus reset flags", 5'b11110, 5'b11110, 20);
    check_eq("status after SE0", status, 5'b11110);
    leave_suspend();
  endtask

  task automatic sense_drop_wake();
    logic [1:0] pat;
    pick_speed(pat);
    set_idle(pat);
    enter_suspend();
    usb_sense = 1'b0;
    repeat (10) @(negedge clk_aon);
    usb_sense = 1'b1;
    wait_status("sense lost flags", 5'b11001, 5'b11001, 20);
    check_eq("status after sense drop", status, 5'b11001);
    leave_suspend();
  endtask

  task automatic glitch_reject();
    logic [1:0] pat;
    pick_speed(pat);
    set_idle(pat);
    enter_suspend();
    // Single clock K, then SE0, then sense drop
    {usb_dp, usb_dn} = ~pat;
    @(negedge clk_aon);
    {usb_dp, usb_dn} = 2'b00;
    @(negedge clk_aon);
    {usb_dp, usb_dn} = pat;
    usb_sense        = 1'b0;
    @(negedge clk_aon);
    usb_sense = 1'b1;
    repeat (15) @(negedge clk_aon);
    check_eq("status after glitches", status, 5'b10000);
    leave_suspend();
    // A real K while idle is ignored
    {usb_dp, usb_dn} = ~pat;
    repeat (10) @(negedge clk_aon);
    check_eq("status after idle K", status, 5'b00000);
    set_idle(pat);
  endtask

  initial begin
    rst_aon_n   = 1'b0;
    usb_dp      = 1'b1;
    usb_dn      = 1'b0;
    usb_sense   = 1'b1;
    ip_dp_en    = 1'b1;
    ip_dn_en    = 1'b0;
    suspend_req = 1'b0;
    wake_ack    = 1'b0;
    lfsr_q      = 8'd92;
    err_cnt     = 0;
    check_cnt   = 0;
    repeat (8) @(negedge clk_aon);
    rst_aon_n = 1'b1;
    @(negedge clk_aon);
    idle_follow();
    suspend_entry();
    resume_wake();
    bus_reset_wake();
    sense_drop_wake();
    glitch_reject();
    $display("checks %0d errors %0d assertion failures %0d", check_cnt, err_cnt,
             usb_aon_wake_i.u_checker.fail_cnt);
    if ((err_cnt == 0) && (usb_aon_wake_i.u_checker.fail_cnt == 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
design/usb_aon_pkg.sv
design/usb_sync_filter.sv
design/usb_line_monitor.sv
design/usb_pullup_hold.sv
design/usb_aon_wake_ctrl.sv
design/usb_aon_wake.sv
tb/usb_aon_wake_checker.sv
tb/tb_usb_aon_wake.sv

// ==== Makefile ====
# Verilator flow for the always-on USB wake detector
# Any variable below can be overridden on the command line

VERILATOR  ?= verilator
TOP        ?= tb_usb_aon_wake
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, so a crash without a verdict also fails
run: build
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
